/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_fetch_unit
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* cache_ram.sv */
`timescale 1ns/10ps

module cache_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 1024
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, output holds while disabled
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* fetch_buffer.sv */
`timescale 1ns/10ps

module fetch_buffer import ifu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold,           // decode stall
    input  logic        cache_stall,
    input  logic        redirect,
    input  fetch_addr_t pc,
    input  logic [31:0] inst_data,
    output logic [31:0] inst,
    output logic [31:0] inst_pc,
    output logic        inst_valid
);

    logic capture;

    // the cache has a word for pc and decode can take it
    assign capture = !hold && !cache_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid <= 1'b0;
        end else if (redirect) begin
            inst_valid <= 1'b0;             // wrong-path word dropped
        end else if (!hold) begin
            inst_valid <= !cache_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            inst    <= inst_data;
            inst_pc <= pc.raw;
        end
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/10ps
`include "ifu_settings.svh"

module fetch_unit import ifu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    // decode side
    input  logic                      decode_stall,
    input  logic                      redirect,
    input  logic [31:0]               redirect_pc,
    output logic [31:0]               inst,
    output logic [31:0]               inst_pc,
    output logic                      inst_valid,
    // memory read port
    output logic [31:0]               araddr,
    output logic [`IFU_LEN_WIDTH-1:0] arlen,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [31:0]               rdata,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready
);

    fetch_addr_t pc;
    fetch_addr_t pc_next;
    logic        fetch_en;
    logic        cache_stall;
    logic [31:0] inst_data;

    pc_gen u_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .hold        (decode_stall),
        .cache_stall (cache_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .pc_next     (pc_next),
        .fetch_en    (fetch_en)
    );

    i_cache u_i_cache (
        .clk         (clk),
        .rst         (rst),
        .fetch_en    (fetch_en),
        .pc          (pc),
        .pc_next     (pc_next),
        .stallF      (decode_stall),
        .inst_data   (inst_data),
        .cache_stall (cache_stall),
        .araddr      (araddr),
        .arlen       (arlen),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    fetch_buffer u_fetch_buffer (
        .clk         (clk),
        .rst         (rst),
        .hold        (decode_stall),
        .cache_stall (cache_stall),
        .redirect    (redirect),
        .pc          (pc),
        .inst_data   (inst_data),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_valid  (inst_valid)
    );

endmodule

/* files.f */
+incdir+.
ifu_pkg.sv
cache_ram.sv
pc_gen.sv
i_cache.sv
fetch_buffer.sv
fetch_unit.sv
tb_fetch_unit.sv

/* i_cache.sv */
`timescale 1ns/10ps
`include "ifu_settings.svh"

module i_cache import ifu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_en,
    input  fetch_addr_t               pc,          // address under lookup
    input  fetch_addr_t               pc_next,     // address read this cycle
    input  logic                      stallF,
    output logic [31:0]               inst_data,
    output logic                      cache_stall,
    // refill read port
    output logic [31:0]               araddr,
    output logic [`IFU_LEN_WIDTH-1:0] arlen,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [31:0]               rdata,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready
);

    localparam int TW = `IFU_TAG_WIDTH;

    localparam logic [1:0] IDLE       = 2'b00;
    localparam logic [1:0] HitJudge   = 2'b01;
    localparam logic [1:0] LoadMemory = 2'b11;

    logic [1:0] state;

    // way RAM read side
    logic        rd_en;
    logic [TW:0] tag_way0;      // {tag, valid}
    logic [TW:0] tag_way1;
    logic [31:0] data_way0;
    logic [31:0] data_way1;

    // per-set state kept in flops so that reset clears it
    logic [`IFU_SETS-1:0] valid_way0;
    logic [`IFU_SETS-1:0] valid_way1;
    logic [`IFU_SETS-1:0] lru_bits;     // way to replace next

    logic hit_way0;
    logic hit_way1;
    logic hit;

    // refill
    fetch_addr_t miss_addr;
    logic        evict_way;
    logic        refill_done;
    logic        deliver;
    logic        wr_way0;
    logic        wr_way1;
    logic [TW:0] tag_wr_data;

    // RAMs follow pc_next while a lookup can start or continue
    assign rd_en = (state == IDLE && fetch_en && !stallF) || state == HitJudge;

    assign hit_way0 = valid_way0[pc.fields.index] && tag_way0[0]
                      && (tag_way0[TW:1] == pc.fields.tag);
    assign hit_way1 = valid_way1[pc.fields.index] && tag_way1[0]
                      && (tag_way1[TW:1] == pc.fields.tag);
    assign hit      = (state == HitJudge) && (hit_way0 || hit_way1);

    assign refill_done = (state == LoadMemory) && rready && rvalid && rlast;

    // a redirect during the refill leaves the word in the cache only
    assign deliver = refill_done && (miss_addr.raw == pc.raw);

    assign cache_stall = !(hit || deliver);
    assign inst_data   = (state == LoadMemory) ? rdata :
                         (hit_way1 ? data_way1 : data_way0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_en) begin
                        state <= HitJudge;
                    end
                end
                HitJudge: begin
                    if (!hit) begin
                        state <= LoadMemory;    // miss
                    end
                end
                LoadMemory: begin
                    if (refill_done) begin
                        state <= IDLE;          // re-read before next lookup
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // missing address, held for the whole refill
    always_ff @(posedge clk) begin
        if (state == HitJudge && !hit) begin
            miss_addr <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            if (state == HitJudge && !hit) begin
                arvalid <= 1'b1;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rready <= 1'b1;             // accept data after the address
            end else if (refill_done) begin
                rready <= 1'b0;
            end
        end
    end

    assign araddr = miss_addr.raw;
    assign arlen  = `IFU_REFILL_LEN;

    // victim way and write side
    assign evict_way   = lru_bits[miss_addr.fields.index];
    assign wr_way0     = refill_done && !evict_way;
    assign wr_way1     = refill_done && evict_way;
    assign tag_wr_data = {miss_addr.fields.tag, 1'b1};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_way0 <= '0;
            valid_way1 <= '0;
            lru_bits   <= '0;
        end else begin
            if (wr_way0) begin
                valid_way0[miss_addr.fields.index] <= 1'b1;
            end
            if (wr_way1) begin
                valid_way1[miss_addr.fields.index] <= 1'b1;
            end
            if (hit) begin
                lru_bits[pc.fields.index] <= !hit_way1;           // point at other way
            end else if (refill_done) begin
                lru_bits[miss_addr.fields.index] <= !evict_way;
            end
        end
    end

    cache_ram #(.WIDTH(TW + 1), .DEPTH(`IFU_SETS)) tag_ram_way0 (
        .clk     (clk),
        .wr_en   (wr_way0),
        .wr_addr (miss_addr.fields.index),
        .wr_data (tag_wr_data),
        .rd_en   (rd_en),
        .rd_addr (pc_next.fields.index),
        .rd_data (tag_way0)
    );

    cache_ram #(.WIDTH(TW + 1), .DEPTH(`IFU_SETS)) tag_ram_way1 (
        .clk     (clk),
        .wr_en   (wr_way1),
        .wr_addr (miss_addr.fields.index),
        .wr_data (tag_wr_data),
        .rd_en   (rd_en),
        .rd_addr (pc_next.fields.index),
        .rd_data (tag_way1)
    );

    cache_ram #(.WIDTH(32), .DEPTH(`IFU_SETS)) data_ram_way0 (
        .clk     (clk),
        .wr_en   (wr_way0),
        .wr_addr (miss_addr.fields.index),
        .wr_data (rdata),
        .rd_en   (rd_en),
        .rd_addr (pc_next.fields.index),
        .rd_data (data_way0)
    );

    cache_ram #(.WIDTH(32), .DEPTH(`IFU_SETS)) data_ram_way1 (
        .clk     (clk),
        .wr_en   (wr_way1),
        .wr_addr (miss_addr.fields.index),
        .wr_data (rdata),
        .rd_en   (rd_en),
        .rd_addr (pc_next.fields.index),
        .rd_data (data_way1)
    );

endmodule

/* ifu_pkg.sv */
`include "ifu_settings.svh"

package ifu_pkg;

    // field view of a fetch address, msb first
    typedef struct packed {
        logic [`IFU_TAG_WIDTH-1:0]    tag;
        logic [`IFU_INDEX_WIDTH-1:0]  index;    // set select
        logic [`IFU_OFFSET_WIDTH-1:0] offset;   // byte within the word
    } fetch_addr_fields_t;

    // the same fetch address seen as a plain word or split for lookup
    typedef union packed {
        logic [31:0]        raw;      // written by pc_gen
        fetch_addr_fields_t fields;   // decoded by i_cache
    } fetch_addr_t;

endpackage

/* ifu_settings.svh */
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// fetch address split into tag, index and offset
`define IFU_TAG_WIDTH    20
`define IFU_INDEX_WIDTH  10
`define IFU_OFFSET_WIDTH 2      // one 32-bit word per line

// sets in each way
`define IFU_SETS         (1 << `IFU_INDEX_WIDTH)

// first fetch address after reset
`define IFU_RESET_PC     32'h0000_1000

// refill read port
`define IFU_LEN_WIDTH    8      // burst length field width
`define IFU_REFILL_LEN   8'd0   // single beat per refill

`endif

/* pc_gen.sv */
`timescale 1ns/10ps
`include "ifu_settings.svh"

module pc_gen import ifu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold,          // decode stall
    input  logic        cache_stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output fetch_addr_t pc,
    output fetch_addr_t pc_next,
    output logic        fetch_en
);

    logic advance;

    // fetch_en is low for one cycle after reset, so the first RAM read
    // address is the reset PC itself rather than the step after it
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    assign advance = fetch_en && !hold && !cache_stall;

    // next fetch address, also the cache RAM read address
    always_comb begin
        if (redirect) begin
            pc_next.raw = redirect_pc;      // redirect wins over any stall
        end else if (advance) begin
            pc_next.raw = pc.raw + 32'd4;
        end else begin
            pc_next.raw = pc.raw;           // held
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc.raw <= `IFU_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* tb_fetch_unit.sv */
`timescale 1ns/10ps
`include "ifu_settings.svh"

module tb_fetch_unit;

    localparam int ROWS           = 9;
    localparam int ROW_TIMEOUT    = 2000;
    localparam int SETTLE_TIMEOUT = 200;
    localparam logic [31:0] MARK  = 32'hA5A5_0000;    // memory word is address ^ MARK

    localparam logic [1:0] MEM_IDLE = 2'd0;
    localparam logic [1:0] MEM_WAIT = 2'd1;
    localparam logic [1:0] MEM_ADDR = 2'd2;
    localparam logic [1:0] MEM_DATA = 2'd3;

    logic                      clk;
    logic                      rst;
    logic                      decode_stall;
    logic                      redirect;
    logic [31:0]               redirect_pc;
    logic [31:0]               inst;
    logic [31:0]               inst_pc;
    logic                      inst_valid;
    logic [31:0]               araddr;
    logic [`IFU_LEN_WIDTH-1:0] arlen;
    logic                      arvalid;
    logic                      arready;
    logic [31:0]               rdata;
    logic                      rlast;
    logic                      rvalid;
    logic                      rready;

    // name, redirect target, instructions taken, address requests inside the row's range
    // lru rows share set 0x140 with tags 0x40, 0x80 and 0xc0
    string       row_name   [ROWS] = '{"reset_pass", "warm_pass", "lru_fill_a", "lru_fill_b",
                                       "lru_touch_a", "lru_fill_c", "lru_keep_a", "lru_lost_b",
                                       "stall_stream"};
    logic [31:0] row_target [ROWS] = '{`IFU_RESET_PC, `IFU_RESET_PC, 32'h0004_0500,
                                       32'h0008_0500, 32'h0004_0500, 32'h000C_0500,
                                       32'h0004_0500, 32'h0008_0500, 32'h0010_2000};
    int          row_count  [ROWS] = '{16, 16, 1, 1, 1, 1, 1, 1, 40};
    int          row_reqs   [ROWS] = '{16, 0, 1, 1, 0, 1, 0, 1, 40};

    int          cur_row;
    int          consumed;
    int          req_count;
    int          waited;
    int          quiet;
    logic [31:0] next_exp;          // pc decode should take next
    logic [31:0] row_hi;
    logic        arvalid_q;
    logic        port_busy;
    logic [15:0] lfsr;
    logic [1:0]  mem_state;
    logic [1:0]  mem_wait;

    fetch_unit DUT (
        .clk          (clk),
        .rst          (rst),
        .decode_stall (decode_stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .inst_valid   (inst_valid),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // taps 16 14 13 11
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected %h actual %h", row_name[cur_row], label,
                     expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s: %s", row_name[cur_row], reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    // read-only memory, one beat per request after a random address delay
    task automatic serve_memory();
        logic b0;
        logic b1;
        case (mem_state)
            MEM_IDLE: begin
                if (arvalid) begin
                    take_bit(b0);
                    take_bit(b1);
                    mem_wait  = {b1, b0};
                    mem_state = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (mem_wait == 2'd0) begin
                    arready  <= 1'b1;
                    mem_state = MEM_ADDR;
                end else begin
                    mem_wait = mem_wait - 2'd1;
                end
            end
            MEM_ADDR: begin
                if (arvalid) begin
                    arready  <= 1'b0;       // address accepted this edge
                    rdata    <= araddr ^ MARK;
                    rvalid   <= 1'b1;
                    rlast    <= 1'b1;
                    mem_state = MEM_DATA;
                end else begin
                    stop_run("arvalid dropped before the address handshake");
                end
            end
            default: begin
                if (rready) begin
                    rvalid   <= 1'b0;
                    rlast    <= 1'b0;
                    mem_state = MEM_IDLE;
                end
            end
        endcase
    endtask

    // one clock: sample outputs of the cycle just ended, then drive the next one
    task automatic step_cycle();
        logic stall_bit;
        @(posedge clk);
        port_busy = arvalid || rready;
        if (arvalid && !arvalid_q) begin
            check_value("arlen", 32'd0, 32'(arlen));
            // the lookup runs at most one pc ahead of decode
            if (araddr != next_exp && araddr != next_exp + 32'd4) begin
                check_value("araddr", next_exp, araddr);
            end
            if (araddr >= row_target[cur_row] && araddr < row_hi) begin
                req_count++;
            end
        end
        arvalid_q = arvalid;
        if (mem_state != MEM_DATA) begin
            check_value("rready", 32'd0, 32'(rready));
        end
        if (inst_valid && !decode_stall && !redirect) begin     // decode takes it
            check_value("inst_pc", next_exp, inst_pc);
            check_value("inst", next_exp ^ MARK, inst);
            next_exp = next_exp + 32'd4;
            consumed++;
        end
        serve_memory();
        take_bit(stall_bit);
        redirect     <= 1'b0;
        decode_stall <= (consumed < row_count[cur_row]) ? stall_bit : 1'b1;
    endtask

    initial begin
        rst          = 1'b1;
        decode_stall = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = 32'd0;
        arready      = 1'b0;
        rdata        = 32'd0;
        rlast        = 1'b0;
        rvalid       = 1'b0;
        lfsr         = 16'd95;
        mem_state    = MEM_IDLE;
        mem_wait     = 2'd0;
        arvalid_q    = 1'b0;
        cur_row      = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            if (r > 0) begin
                quiet  = 0;
                waited = 0;
                while (quiet < 4) begin         // let any refill of the old path finish
                    step_cycle();
                    quiet = port_busy ? 0 : quiet + 1;
                    waited++;
                    if (waited > SETTLE_TIMEOUT) begin
                        stop_run("memory port never went idle before the redirect");
                    end
                end
                redirect     <= 1'b1;
                redirect_pc  <= row_target[r];
                decode_stall <= 1'b0;
            end
            cur_row   = r;
            next_exp  = row_target[r];          // first row starts at the reset pc
            row_hi    = row_target[r] + 32'(4 * row_count[r]);
            consumed  = 0;
            req_count = 0;
            waited    = 0;
            while (consumed < row_count[r]) begin
                step_cycle();
                waited++;
                if (waited > ROW_TIMEOUT) begin
                    stop_run("fetch unit stopped delivering instructions");
                end
            end
            check_value("requests", row_reqs[r], req_count);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule
